// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mips_exec \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_mips_exec 2>&1 | tee sim.log \
	|| { echo "Simulation exited with an error"; exit 1; }
grep -q "TB FAILED" sim.log && { echo "Failure reported in sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "No pass message in sim.log"; exit 1; }
exit 0

// File: source/alu.sv
`default_nettype none

module alu (
	input  mips_pkg::alu_op_e               alu_op,
	input  logic [mips_pkg::DATA_W-1:0]     operand_a,
	input  logic [mips_pkg::DATA_W-1:0]     operand_b,
	input  logic [mips_pkg::REG_ADDR_W-1:0] shift_amount,

	output logic [mips_pkg::DATA_W-1:0]     result
);
	import mips_pkg::*;

	localparam int HALF_W = DATA_W / 2;

	logic less_signed;
	logic less_unsigned;

	assign less_signed   = $signed(operand_a) < $signed(operand_b);
	assign less_unsigned = operand_a < operand_b;

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = operand_a + operand_b;
			ALU_SUB:  result = operand_a - operand_b;
			ALU_AND:  result = operand_a & operand_b;
			ALU_OR:   result = operand_a | operand_b;
			ALU_XOR:  result = operand_a ^ operand_b;
			ALU_NOR:  result = ~(operand_a | operand_b);
			ALU_SLT:  result = {{(DATA_W-1){1'b0}}, less_signed};
			ALU_SLTU: result = {{(DATA_W-1){1'b0}}, less_unsigned};
			ALU_SLL:  result = operand_b << shift_amount; // Shifts act on rt
			ALU_SRL:  result = operand_b >> shift_amount;
			ALU_SRA:  result = $unsigned($signed(operand_b) >>> shift_amount);
			ALU_LUI:  result = {operand_b[HALF_W-1:0], {HALF_W{1'b0}}};
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/control_unit.sv
`default_nettype none

module control_unit (
	input  logic [31:0]         instruction,

	output logic                reg_write,
	output logic                reg_dst_rd,
	output logic                alu_src_imm,
	output logic                shift_by_shamt,
	output logic                shift_by_rs,
	output logic                zero_extend,
	output mips_pkg::alu_op_e   alu_op,
	output mips_pkg::hi_lo_op_e hi_lo_op,
	output logic                read_hi,
	output logic                result_from_hi_lo,
	output logic                illegal
);
	import mips_pkg::*;

	opcode_e               opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rt;

	assign opcode = opcode_e'(instruction[31:26]);
	assign rt     = instruction[20:16];
	assign funct  = funct_e'(instruction[5:0]);

	always_comb begin
		reg_write         = 1'b0;
		reg_dst_rd        = 1'b0;
		alu_src_imm       = 1'b0;
		shift_by_shamt    = 1'b0;
		shift_by_rs       = 1'b0;
		zero_extend       = 1'b0;
		alu_op            = ALU_ADD;
		hi_lo_op          = HL_NONE;
		read_hi           = 1'b0;
		result_from_hi_lo = 1'b0;
		illegal           = 1'b0;

		case (opcode)
			OP_SPECIAL: begin
				reg_write      = 1'b1;
				reg_dst_rd     = 1'b1;
				shift_by_shamt = funct inside {FN_SLL, FN_SRL, FN_SRA};
				shift_by_rs    = funct inside {FN_SLLV, FN_SRLV, FN_SRAV};
				case (funct)
					FN_SLL, FN_SLLV: alu_op = ALU_SLL;
					FN_SRL, FN_SRLV: alu_op = ALU_SRL;
					FN_SRA, FN_SRAV: alu_op = ALU_SRA;
					FN_ADD, FN_ADDU: alu_op = ALU_ADD; // No overflow trap
					FN_SUB, FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_MFHI, FN_MFLO: begin
						result_from_hi_lo = 1'b1;
						read_hi           = (funct == FN_MFHI);
						if (rt != '0) begin // rt field must be zero
							reg_write = 1'b0;
							illegal   = 1'b1;
						end
					end
					FN_MTHI, FN_MTLO: begin
						reg_write = 1'b0;
						if (rt != '0) begin
							illegal = 1'b1;
						end else begin
							hi_lo_op = (funct == FN_MTHI) ? HL_MTHI : HL_MTLO;
						end
					end
					FN_MULT: begin
						reg_write = 1'b0;
						hi_lo_op  = HL_MULT;
					end
					FN_MULTU: begin
						reg_write = 1'b0;
						hi_lo_op  = HL_MULTU;
					end
					default: begin // DIV, jumps, syscalls, unknown
						reg_write = 1'b0;
						illegal   = 1'b1;
					end
				endcase
			end

			OP_ADDI, OP_ADDIU: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = ALU_ADD;
			end
			OP_SLTI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = ALU_SLT;
			end
			OP_SLTIU: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = ALU_SLTU; // Sign-extended yet compared unsigned
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				zero_extend = 1'b1;
				case (opcode)
					OP_ANDI: alu_op = ALU_AND;
					OP_ORI:  alu_op = ALU_OR;
					default: alu_op = ALU_XOR;
				endcase
			end
			OP_LUI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_op      = ALU_LUI;
			end

			default: illegal = 1'b1; // Branches, jumps, loads, stores
		endcase
	end

endmodule

`default_nettype wire

// File: source/hi_lo_unit.sv
`default_nettype none

module hi_lo_unit (
	input  logic                        clk,
	input  logic                        rst,
	input  mips_pkg::hi_lo_op_e         hi_lo_op,
	input  logic                        read_hi,
	input  logic [mips_pkg::DATA_W-1:0] rs_data,
	input  logic [mips_pkg::DATA_W-1:0] rt_data,

	output logic [mips_pkg::DATA_W-1:0] read_data
);
	import mips_pkg::*;

	logic [DATA_W-1:0]   hi;
	logic [DATA_W-1:0]   lo;
	logic                is_signed;
	logic [2*DATA_W-1:0] wide_a;
	logic [2*DATA_W-1:0] wide_b;
	logic [2*DATA_W-1:0] product;

	// One multiplier serves both as only the extension differs
	assign is_signed = (hi_lo_op == HL_MULT);
	assign wide_a    = {{DATA_W{is_signed & rs_data[DATA_W-1]}}, rs_data};
	assign wide_b    = {{DATA_W{is_signed & rt_data[DATA_W-1]}}, rt_data};
	assign product   = wide_a * wide_b; // Low 64 bits of the extended product

	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else begin
			case (hi_lo_op)
				HL_MULT, HL_MULTU: begin
					hi <= product[2*DATA_W-1:DATA_W];
					lo <= product[DATA_W-1:0];
				end
				HL_MTHI: hi <= rs_data;
				HL_MTLO: lo <= rs_data;
				default: begin
				end
			endcase
		end
	end

	assign read_data = read_hi ? hi : lo; // MFHI or MFLO

endmodule

`default_nettype wire

// File: source/mips_exec_top.sv
`default_nettype none

module mips_exec_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            instr_valid,
	input  logic [31:0]                     instruction,

	output logic                            wb_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] wb_reg,
	output logic [mips_pkg::DATA_W-1:0]     wb_data,
	output logic                            illegal
);
	import mips_pkg::*;

	localparam int IMM_W = 16;

	logic [REG_ADDR_W-1:0] rs_addr, rt_addr, rd_addr, shamt;
	logic [IMM_W-1:0]      imm;
	logic [REG_ADDR_W-1:0] dest_addr;
	logic [REG_ADDR_W-1:0] shift_amount;
	logic [DATA_W-1:0]     rs_data, rt_data;
	logic [DATA_W-1:0]     imm_ext;
	logic [DATA_W-1:0]     operand_b;
	logic [DATA_W-1:0]     alu_result;
	logic [DATA_W-1:0]     hi_lo_data;
	logic [DATA_W-1:0]     result;

	logic      reg_write, reg_dst_rd, alu_src_imm;
	logic      shift_by_shamt, shift_by_rs, zero_extend;
	logic      read_hi, result_from_hi_lo, decode_illegal;
	logic      write_en;
	alu_op_e   alu_op;
	hi_lo_op_e hi_lo_op;
	hi_lo_op_e hi_lo_op_gated;

	assign rs_addr = instruction[25:21];
	assign rt_addr = instruction[20:16];
	assign rd_addr = instruction[15:11];
	assign shamt   = instruction[10:6];
	assign imm     = instruction[IMM_W-1:0];

	control_unit u_control (
		.instruction       (instruction),
		.reg_write         (reg_write),
		.reg_dst_rd        (reg_dst_rd),
		.alu_src_imm       (alu_src_imm),
		.shift_by_shamt    (shift_by_shamt),
		.shift_by_rs       (shift_by_rs),
		.zero_extend       (zero_extend),
		.alu_op            (alu_op),
		.hi_lo_op          (hi_lo_op),
		.read_hi           (read_hi),
		.result_from_hi_lo (result_from_hi_lo),
		.illegal           (decode_illegal)
	);

	assign dest_addr = reg_dst_rd ? rd_addr : rt_addr;
	assign imm_ext   = zero_extend ? {{(DATA_W-IMM_W){1'b0}}, imm}
	                               : {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
	assign operand_b = alu_src_imm ? imm_ext : rt_data;
	assign shift_amount = shift_by_rs    ? rs_data[REG_ADDR_W-1:0] :
	                      shift_by_shamt ? shamt : '0;

	// Nothing changes state unless the strobe is up
	assign write_en       = instr_valid & reg_write;
	assign hi_lo_op_gated = instr_valid ? hi_lo_op : HL_NONE;
	assign result         = result_from_hi_lo ? hi_lo_data : alu_result;

	register_file u_regs (
		.clk        (clk),
		.rst        (rst),
		.rs_addr    (rs_addr),
		.rt_addr    (rt_addr),
		.write_en   (write_en),
		.write_addr (dest_addr),
		.write_data (result),
		.rs_data    (rs_data),
		.rt_data    (rt_data)
	);

	alu u_alu (
		.alu_op       (alu_op),
		.operand_a    (rs_data),
		.operand_b    (operand_b),
		.shift_amount (shift_amount),
		.result       (alu_result)
	);

	hi_lo_unit u_hi_lo (
		.clk       (clk),
		.rst       (rst),
		.hi_lo_op  (hi_lo_op_gated),
		.read_hi   (read_hi),
		.rs_data   (rs_data),
		.rt_data   (rt_data),
		.read_data (hi_lo_data)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			wb_valid <= write_en;
			illegal  <= instr_valid & decode_illegal;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= dest_addr; // Same edge as the register write
		wb_data <= result;
	end

endmodule

`default_nettype wire

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;

	// Major opcodes in instruction[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// SPECIAL function codes in instruction[5:0]
	typedef enum logic [5:0] {
		FN_SLL   = 6'b000000,
		FN_SRL   = 6'b000010,
		FN_SRA   = 6'b000011,
		FN_SLLV  = 6'b000100,
		FN_SRLV  = 6'b000110,
		FN_SRAV  = 6'b000111,
		FN_MFHI  = 6'b010000,
		FN_MTHI  = 6'b010001,
		FN_MFLO  = 6'b010010,
		FN_MTLO  = 6'b010011,
		FN_MULT  = 6'b011000,
		FN_MULTU = 6'b011001,
		FN_ADD   = 6'b100000,
		FN_ADDU  = 6'b100001,
		FN_SUB   = 6'b100010,
		FN_SUBU  = 6'b100011,
		FN_AND   = 6'b100100,
		FN_OR    = 6'b100101,
		FN_XOR   = 6'b100110,
		FN_NOR   = 6'b100111,
		FN_SLT   = 6'b101010,
		FN_SLTU  = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		HL_NONE,
		HL_MULT,
		HL_MULTU,
		HL_MTHI,
		HL_MTLO
	} hi_lo_op_e;

endpackage

`default_nettype wire

// File: source/register_file.sv
`default_nettype none

module register_file (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
	input  logic                            write_en,
	input  logic [mips_pkg::REG_ADDR_W-1:0] write_addr,
	input  logic [mips_pkg::DATA_W-1:0]     write_data,

	output logic [mips_pkg::DATA_W-1:0]     rs_data,
	output logic [mips_pkg::DATA_W-1:0]     rt_data
);
	import mips_pkg::*;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	logic [DATA_W-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && write_addr != '0) begin // $zero never written
			regs[write_addr] <= write_data;
		end
	end

	// A write at T is seen by reads from T onward
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

// File: tb.f
source/mips_pkg.sv
source/control_unit.sv
source/register_file.sv
source/alu.sv
source/hi_lo_unit.sv
source/mips_exec_top.sv
tb/mips_exec_sva.sv
tb/tb_mips_exec.sv

// File: tb/exec_tests.mem
// tag  instruction  kind  reg  data, all hex words
// kind 0 silent, 1 write, 2 illegal; plus 10 to issue right after the previous test
0101 00000810 01 01 00000000 // mfhi $1
0102 00001012 01 02 00000000 // mflo $2
0103 00851821 01 03 00000000 // addu $3,$4,$5
0201 2001FFFB 01 01 FFFFFFFB // addi $1,$0,-5
0202 2422FFFF 11 02 FFFFFFFA // addiu $2,$1,-1
0203 34038001 01 03 00008001 // ori $3,$0,0x8001
0204 3024FF0F 01 04 0000FF0B // andi $4,$1,0xff0f
0205 38258000 01 05 FFFF7FFB // xori $5,$1,0x8000
0206 3C061234 01 06 12340000 // lui $6,0x1234
0207 2827FFFC 01 07 00000001 // slti $7,$1,-4
0208 2C69FFFF 01 09 00000001 // sltiu $9,$3,-1
0209 2C2A0010 01 0A 00000000 // sltiu $10,$1,16
0301 00C35820 01 0B 12348001 // add $11,$6,$3
0302 00646022 01 0C FFFF80F6 // sub $12,$3,$4
0303 01816823 11 0D FFFF80FB // subu $13,$12,$1
0304 00857024 01 0E 00007F0B // and $14,$4,$5
0305 00C37825 01 0F 12348001 // or $15,$6,$3
0306 01EB8026 11 10 00000000 // xor $16,$15,$11
0307 00608827 01 11 FFFF7FFE // nor $17,$3,$0
0308 0027902A 01 12 00000001 // slt $18,$1,$7
0309 0027982B 01 13 00000000 // sltu $19,$1,$7
030A 0003A100 01 14 00080010 // sll $20,$3,4
030B 0001AA02 01 15 00FFFFFF // srl $21,$1,8
030C 0001B043 01 16 FFFFFFFD // sra $22,$1,1
030D 0086B804 01 17 A0000000 // sllv $23,$6,$4
030E 00E5C007 01 18 FFFFBFFD // srav $24,$5,$7
030F 0297C806 01 19 0000A000 // srlv $25,$23,$20
0401 00240018 00 00 00000000 // mult $1,$4
0402 0000D010 01 1A FFFFFFFF // mfhi $26
0403 0000D812 01 1B FFFB04C9 // mflo $27
0404 00220019 00 00 00000000 // multu $1,$2
0405 0000D010 11 1A FFFFFFF5 // mfhi $26
0406 0000D812 01 1B 0000001E // mflo $27
0407 00C00011 00 00 00000000 // mthi $6
0408 00600013 00 00 00000000 // mtlo $3
0409 0000E010 01 1C 12340000 // mfhi $28
040A 0000E812 01 1D 00008001 // mflo $29
0501 24C00055 01 00 12340055 // addiu $0,$6,0x55
0502 0000F021 11 1E 00000000 // addu $30,$0,$0
0601 8C270000 02 00 00000000 // lw $7,0($1)
0602 10220004 02 00 00000000 // beq $1,$2,4
0603 0022001A 02 00 00000000 // div $1,$2
0604 00E0F825 01 1F 00000001 // or $31,$7,$0
0605 0000F812 01 1F 00008001 // mflo $31

// File: tb/mips_exec_sva.sv
`default_nettype none

module mips_exec_sva (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic wb_valid,
	input logic illegal
);
	timeunit 1ns;
	timeprecision 100ps;

	report_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(wb_valid && illegal))
		else $error("wb_valid and illegal high in the same cycle");

	// A report always traces back to an accepted instruction
	report_has_source: assert property (@(posedge clk) disable iff (rst)
		(wb_valid || illegal) |-> $past(instr_valid))
		else $error("report without instr_valid in the previous cycle");

	quiet_after_reset: assert property (@(posedge clk)
		rst |=> (!wb_valid && !illegal))
		else $error("report in the cycle after reset");

endmodule

bind mips_exec_top mips_exec_sva u_sva (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.wb_valid    (wb_valid),
	.illegal     (illegal)
);

`default_nettype wire

// File: tb/tb_mips_exec.sv
`default_nettype none

module tb_mips_exec;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int         MAX_TESTS    = 100;
	localparam int         FIELDS       = 5; // tag, instruction, kind, reg, data
	localparam int         DEPTH        = 512;
	localparam logic [3:0] KIND_WRITE   = 4'd1;
	localparam logic [3:0] KIND_ILLEGAL = 4'd2;

	logic        clk;
	logic        rst;
	logic        instr_valid;
	logic [31:0] instruction;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        illegal;

	logic [31:0] vectors [DEPTH];
	int          num_tests;
	int          cycle_limit;
	int          cycles;
	int          pass_count;
	int          fail_count;
	int          idle_errors;
	int          seed;

	mips_exec_top UUT (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instruction (instruction),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.illegal     (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Simulation timed out after %0d cycles", cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	// Junk on the bus with the strobe low must stay silent
	task automatic idle_cycle();
		instr_valid = 1'b0;
		instruction = $random(seed);
		@(posedge clk);
		@(negedge clk);
		if (wb_valid !== 1'b0 || illegal !== 1'b0) begin
			$display("Report seen after an idle cycle, wb_valid %b illegal %b", wb_valid, illegal);
			idle_errors++;
		end
	endtask

	task automatic check_report(input logic [15:0] tag, input logic [3:0] kind,
			input logic [4:0] exp_reg, input logic [31:0] exp_data);
		logic exp_valid;
		logic exp_illegal;
		int   bad;
		exp_valid   = (kind == KIND_WRITE);
		exp_illegal = (kind == KIND_ILLEGAL);
		bad         = 0;
		if (wb_valid !== exp_valid) begin
			$display("FAIL test %04h wb_valid expected %b actual %b", tag, exp_valid, wb_valid);
			bad++;
		end
		if (illegal !== exp_illegal) begin
			$display("FAIL test %04h illegal expected %b actual %b", tag, exp_illegal, illegal);
			bad++;
		end
		if (exp_valid && wb_reg !== exp_reg) begin
			$display("FAIL test %04h wb_reg expected %0d actual %0d", tag, exp_reg, wb_reg);
			bad++;
		end
		if (exp_valid && wb_data !== exp_data) begin
			$display("FAIL test %04h wb_data expected %08h actual %08h", tag, exp_data, wb_data);
			bad++;
		end
		if (bad == 0) begin
			pass_count++;
			$display("test %04h ok", tag);
		end else begin
			fail_count++;
			$display("test %04h failed", tag);
		end
	endtask

	initial begin
		logic [8:0]  base;
		logic [31:0] kind_word;
		int          gap;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instruction = '0;
		seed        = 32'h6cea;
		cycles      = 0;
		pass_count  = 0;
		fail_count  = 0;
		idle_errors = 0;
		foreach (vectors[i]) vectors[i] = '1; // All ones tag marks the end
		$readmemh("tb/exec_tests.mem", vectors);
		num_tests = 0;
		while (num_tests < MAX_TESTS && vectors[9'(FIELDS * num_tests)] != '1) begin
			num_tests++;
		end
		if (num_tests == 0) begin
			$display("No tests could be loaded from tb/exec_tests.mem");
		end
		cycle_limit = 4 * num_tests + 40; // Longest gap plus the issue cycle

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int t = 0; t < num_tests; t++) begin
			base      = 9'(FIELDS * t);
			kind_word = vectors[base + 9'd2];
			if (!kind_word[4]) begin // Bit 4 asks for a back-to-back issue
				gap = $unsigned($random(seed)) % 4;
				repeat (gap) idle_cycle();
			end
			instruction = vectors[base + 9'd1];
			instr_valid = 1'b1;
			@(posedge clk);
			@(negedge clk);
			instr_valid = 1'b0;
			check_report(vectors[base][15:0], kind_word[3:0], vectors[base + 9'd3][4:0],
				vectors[base + 9'd4]);
		end

		$display("%0d tests passed, %0d failed, %0d idle errors",
			pass_count, fail_count, idle_errors);
		if (fail_count == 0 && idle_errors == 0 && num_tests > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
